//--- Makefile
# Verilator build and run of the processing unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the simulation prints the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- source/pu.sv
// ---------------------------------------------------------
// Processing unit top with memctrl, fetch, buffer, sequencer
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pu (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire pu_pkg::word_addr_t rstaddr_i,
	output pu_pkg::mem_op_e         pi1_op_o,
	output pu_pkg::word_addr_t      pi1_addr_o,
	output pu_pkg::arch_word_t      pi1_data_o,
	input  wire pu_pkg::arch_word_t pi1_data_i,
	input  wire                     pi1_rdy_i,
	output logic                    halted_o,
	output pu_pkg::word_addr_t      pc_o
);

	pu_pkg::mem_req_t   pi1_req;
	logic               fetch_req;
	pu_pkg::word_addr_t fetch_addr;
	logic               fetch_done;
	pu_pkg::arch_word_t fetch_data;
	logic               store_req;
	pu_pkg::word_addr_t store_addr;
	pu_pkg::arch_word_t store_data;
	logic               store_done;
	logic               push;
	pu_pkg::instr_t     push_instr;
	pu_pkg::buf_count_t buf_count;
	logic               pop;
	logic               flush;
	pu_pkg::word_addr_t flush_addr;
	logic               head_valid;
	pu_pkg::instr_t     head_instr;

	assign pi1_op_o   = pi1_req.op;
	assign pi1_addr_o = pi1_req.addr;
	assign pi1_data_o = pi1_req.data;

	pu_memctrl u_memctrl (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
		.fetch_done_o(fetch_done), .fetch_data_o(fetch_data),
		.store_req_i(store_req), .store_addr_i(store_addr),
		.store_data_i(store_data), .store_done_o(store_done),
		.pi1_req_o(pi1_req), .pi1_data_i(pi1_data_i), .pi1_rdy_i(pi1_rdy_i)
	);

	pu_fetch u_fetch (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rstaddr_i(rstaddr_i),
		.buf_count_i(buf_count), .flush_i(flush), .flush_addr_i(flush_addr),
		.halted_i(halted_o),
		.mem_req_o(fetch_req), .mem_addr_o(fetch_addr),
		.mem_done_i(fetch_done), .mem_data_i(fetch_data),
		.push_o(push), .push_instr_o(push_instr)
	);

	pu_instr_buffer u_instr_buffer (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.push_i(push), .push_instr_i(push_instr),
		.pop_i(pop), .flush_i(flush),
		.head_valid_o(head_valid), .head_instr_o(head_instr), .count_o(buf_count)
	);

	pu_sequencer u_sequencer (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rstaddr_i(rstaddr_i),
		.head_valid_i(head_valid), .head_instr_i(head_instr), .pop_o(pop),
		.flush_o(flush), .flush_addr_o(flush_addr),
		.store_req_o(store_req), .store_addr_o(store_addr),
		.store_data_o(store_data), .store_done_i(store_done),
		.halted_o(halted_o), .pc_o(pc_o)
	);

endmodule

`default_nettype wire

//--- source/pu_fetch.sv
// ---------------------------------------------------------
// Program counter and instruction read issue into the buffer
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pu_fetch (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire pu_pkg::word_addr_t rstaddr_i,
	input  wire pu_pkg::buf_count_t buf_count_i,
	input  wire                     flush_i,
	input  wire pu_pkg::word_addr_t flush_addr_i,
	input  wire                     halted_i,
	output logic                    mem_req_o,
	output pu_pkg::word_addr_t      mem_addr_o,
	input  wire                     mem_done_i,
	input  wire pu_pkg::arch_word_t mem_data_i,
	output logic                    push_o,
	output pu_pkg::instr_t          push_instr_o
);

	pu_pkg::word_addr_t pc_q;
	pu_pkg::word_addr_t req_addr_q;
	logic run_q;	// Low until the first clock edge out of reset
	logic outstanding_q;
	logic stale_q;	// In-flight read belongs to the path before a jump
	logic issue;
	logic [pu_pkg::BUF_CNT_W:0] slots_used;

	// Buffered entries plus the one being pushed plus the read in flight
	assign slots_used = {1'b0, buf_count_i}
		+ (pu_pkg::BUF_CNT_W + 1)'(push_o)
		+ (pu_pkg::BUF_CNT_W + 1)'(outstanding_q);

	assign issue = run_q && !outstanding_q && !halted_i && !flush_i
		&& (slots_used < (pu_pkg::BUF_CNT_W + 1)'(pu_pkg::INSTR_BUF_DEPTH));

	assign mem_req_o  = outstanding_q || issue;
	assign mem_addr_o = outstanding_q ? req_addr_q : pc_q;

	// ---------------------------------------------------------
	// Control state
	// ---------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q          <= rstaddr_i;
			run_q         <= 1'b0;
			outstanding_q <= 1'b0;
			stale_q       <= 1'b0;
			push_o        <= 1'b0;
		end else begin
			run_q <= 1'b1;

			if (issue) begin
				outstanding_q <= 1'b1;
			end else if (mem_done_i) begin
				outstanding_q <= 1'b0;
			end

			if (mem_done_i) begin
				stale_q <= 1'b0;
			end else if (flush_i && outstanding_q) begin
				stale_q <= 1'b1;
			end

			if (flush_i) begin
				pc_q <= flush_addr_i;
			end else if (mem_done_i && !stale_q) begin
				pc_q <= pc_q + pu_pkg::word_addr_t'(1);
			end

			push_o <= mem_done_i && !stale_q && !flush_i;
		end
	end

	// Address and payload registers
	always_ff @(posedge clk_i) begin
		if (issue) begin
			req_addr_q <= pc_q;
		end
		if (mem_done_i) begin
			push_instr_o <= pu_pkg::instr_t'(mem_data_i);
		end
	end

endmodule

`default_nettype wire

//--- source/pu_instr_buffer.sv
// ---------------------------------------------------------
// Two-entry instruction FIFO with flush
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pu_instr_buffer (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire                     push_i,
	input  wire pu_pkg::instr_t     push_instr_i,
	input  wire                     pop_i,
	input  wire                     flush_i,
	output logic                    head_valid_o,
	output pu_pkg::instr_t          head_instr_o,
	output pu_pkg::buf_count_t      count_o
);

	pu_pkg::instr_t     entries_q [pu_pkg::INSTR_BUF_DEPTH];
	pu_pkg::buf_ptr_t   wr_ptr_q;
	pu_pkg::buf_ptr_t   rd_ptr_q;
	pu_pkg::buf_count_t count_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || flush_i) begin
			wr_ptr_q <= '0;	// Flush wins over push
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + pu_pkg::buf_ptr_t'(1);
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + pu_pkg::buf_ptr_t'(1);
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + pu_pkg::buf_count_t'(1);
				2'b01:   count_q <= count_q - pu_pkg::buf_count_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			entries_q[wr_ptr_q] <= push_instr_i;
		end
	end

	assign head_valid_o = (count_q != '0);
	assign head_instr_o = entries_q[rd_ptr_q];
	assign count_o      = count_q;

	// Fetch accounts for free slots before issuing a read
	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_i |-> (count_q < pu_pkg::buf_count_t'(pu_pkg::INSTR_BUF_DEPTH)));

endmodule

`default_nettype wire

//--- source/pu_memctrl.sv
// ---------------------------------------------------------
// Arbiter for pi1 between instruction reads and stores
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pu_memctrl (
	input  wire                clk_i,
	input  wire                rst_n_i,
	input  wire                fetch_req_i,
	input  wire pu_pkg::word_addr_t fetch_addr_i,
	output logic               fetch_done_o,
	output pu_pkg::arch_word_t fetch_data_o,
	input  wire                store_req_i,
	input  wire pu_pkg::word_addr_t store_addr_i,
	input  wire pu_pkg::arch_word_t store_data_i,
	output logic               store_done_o,
	output pu_pkg::mem_req_t   pi1_req_o,
	input  wire pu_pkg::arch_word_t pi1_data_i,
	input  wire                pi1_rdy_i
);

	pu_pkg::mem_owner_e owner_q;

	// ---------------------------------------------------------
	// Ownership of pi1
	// ---------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			owner_q <= pu_pkg::OWN_NONE;
		end else begin
			case (owner_q)
				pu_pkg::OWN_NONE: begin
					if (store_req_i) begin
						owner_q <= pu_pkg::OWN_STORE;	// Stores go first
					end else if (fetch_req_i) begin
						owner_q <= pu_pkg::OWN_FETCH;
					end
				end
				default: begin
					if (pi1_rdy_i) begin
						owner_q <= pu_pkg::OWN_NONE;
					end
				end
			endcase
		end
	end

	// ---------------------------------------------------------
	// Request mux and completion routing
	// ---------------------------------------------------------
	always_comb begin
		pi1_req_o.op   = pu_pkg::MEMNOOP;
		pi1_req_o.addr = '0;
		pi1_req_o.data = '0;
		case (owner_q)
			pu_pkg::OWN_STORE: begin
				pi1_req_o.op   = pu_pkg::MEMWRITEOP;
				pi1_req_o.addr = store_addr_i;
				pi1_req_o.data = store_data_i;
			end
			pu_pkg::OWN_FETCH: begin
				pi1_req_o.op   = pu_pkg::MEMREADOP;
				pi1_req_o.addr = fetch_addr_i;
			end
			default: begin
			end
		endcase
	end

	assign fetch_done_o = (owner_q == pu_pkg::OWN_FETCH) && pi1_rdy_i;
	assign store_done_o = (owner_q == pu_pkg::OWN_STORE) && pi1_rdy_i;
	assign fetch_data_o = pi1_data_i;

	// Clients must hold their request until done
	a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(pi1_req_o.op != pu_pkg::MEMNOOP && !pi1_rdy_i) |=> $stable(pi1_req_o));

endmodule

`default_nettype wire

//--- source/pu_pkg.sv
// ---------------------------------------------------------
// Shared widths and word types, opcode and state enums,
// memory request and instruction structs
// ---------------------------------------------------------

`default_nettype none

package pu_pkg;

	// ---------------------------------------------------------
	// Widths and sizes
	// ---------------------------------------------------------
	localparam int ARCH_W          = 32;
	localparam int WADDR_W         = 30;	// Word address without the byte offset
	localparam int GPR_IDX_W       = 4;
	localparam int IMM_W           = 20;
	localparam int INSTR_BUF_DEPTH = 2;
	localparam int GPR_CNT         = 16;
	localparam int BUF_PTR_W       = $clog2(INSTR_BUF_DEPTH);
	localparam int BUF_CNT_W       = $clog2(INSTR_BUF_DEPTH + 1);

	typedef logic [ARCH_W-1:0]    arch_word_t;
	typedef logic [WADDR_W-1:0]   word_addr_t;
	typedef logic [GPR_IDX_W-1:0] gpr_idx_t;
	typedef logic [IMM_W-1:0]     imm_t;
	typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
	typedef logic [BUF_CNT_W-1:0] buf_count_t;	// Holds 0 up to full

	// ---------------------------------------------------------
	// Encodings
	// ---------------------------------------------------------
	typedef enum logic [1:0] {
		MEMNOOP        = 2'b00,
		MEMWRITEOP     = 2'b01,
		MEMREADOP      = 2'b10,
		MEMREADWRITEOP = 2'b11	// Reserved
	} mem_op_e;

	typedef enum logic [3:0] {
		OP_LI   = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_XOR  = 4'h3,
		OP_ST   = 4'h4,
		OP_JMP  = 4'h5,
		OP_HALT = 4'h6
	} opcode_e;

	typedef enum logic [1:0] {
		RUN,
		STORE_WAIT,
		HALTED
	} seq_state_e;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_FETCH,
		OWN_STORE
	} mem_owner_e;

	// Instruction word with the opcode in the top nibble
	typedef struct packed {
		opcode_e  opcode;
		gpr_idx_t rd;
		gpr_idx_t rs;
		imm_t     imm;
	} instr_t;

	typedef struct packed {
		mem_op_e    op;
		word_addr_t addr;
		arch_word_t data;
	} mem_req_t;

endpackage

`default_nettype wire

//--- source/pu_sequencer.sv
// ---------------------------------------------------------
// Decode, register file, ALU, store issue, jump and halt
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pu_sequencer (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire pu_pkg::word_addr_t rstaddr_i,
	input  wire                     head_valid_i,
	input  wire pu_pkg::instr_t     head_instr_i,
	output logic                    pop_o,
	output logic                    flush_o,
	output pu_pkg::word_addr_t      flush_addr_o,
	output logic                    store_req_o,
	output pu_pkg::word_addr_t      store_addr_o,
	output pu_pkg::arch_word_t      store_data_o,
	input  wire                     store_done_i,
	output logic                    halted_o,
	output pu_pkg::word_addr_t      pc_o
);

	pu_pkg::seq_state_e state_q;
	pu_pkg::arch_word_t gpr_q [pu_pkg::GPR_CNT];
	pu_pkg::word_addr_t next_pc_q;	// Address of the current head
	pu_pkg::word_addr_t pc_q;
	pu_pkg::arch_word_t rd_val;
	pu_pkg::arch_word_t rs_val;
	pu_pkg::arch_word_t alu_res;
	pu_pkg::word_addr_t jmp_target;
	logic wr_en;
	logic is_store;
	logic is_jmp;
	logic is_halt;
	logic exec;

	assign rd_val     = gpr_q[head_instr_i.rd];
	assign rs_val     = gpr_q[head_instr_i.rs];
	assign jmp_target = {{(pu_pkg::WADDR_W - pu_pkg::IMM_W){1'b0}}, head_instr_i.imm};
	assign exec       = (state_q == pu_pkg::RUN) && head_valid_i;

	// ---------------------------------------------------------
	// Decode and ALU
	// ---------------------------------------------------------
	always_comb begin
		wr_en    = 1'b0;
		alu_res  = rd_val;
		is_store = 1'b0;
		is_jmp   = 1'b0;
		is_halt  = 1'b0;
		case (head_instr_i.opcode)
			pu_pkg::OP_LI: begin
				wr_en   = 1'b1;
				alu_res = {{(pu_pkg::ARCH_W - pu_pkg::IMM_W){head_instr_i.imm[pu_pkg::IMM_W-1]}},
					head_instr_i.imm};
			end
			pu_pkg::OP_ADD: begin
				wr_en   = 1'b1;
				alu_res = rd_val + rs_val;
			end
			pu_pkg::OP_SUB: begin
				wr_en   = 1'b1;
				alu_res = rd_val - rs_val;
			end
			pu_pkg::OP_XOR: begin
				wr_en   = 1'b1;
				alu_res = rd_val ^ rs_val;
			end
			pu_pkg::OP_ST:   is_store = 1'b1;
			pu_pkg::OP_JMP:  is_jmp   = 1'b1;
			pu_pkg::OP_HALT: is_halt  = 1'b1;
			default: begin
				// Unassigned opcodes retire as no-ops
			end
		endcase
	end

	assign pop_o = (exec && !is_store)
		|| ((state_q == pu_pkg::STORE_WAIT) && store_done_i);
	assign flush_o      = exec && is_jmp;
	assign flush_addr_o = jmp_target;

	// Head stays in the buffer until the store completes
	assign store_req_o  = (state_q == pu_pkg::STORE_WAIT);
	assign store_addr_o = rs_val[pu_pkg::WADDR_W-1:0];
	assign store_data_o = rd_val;

	assign halted_o = (state_q == pu_pkg::HALTED);
	assign pc_o     = pc_q;

	// ---------------------------------------------------------
	// State, register file and retired pc
	// ---------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= pu_pkg::RUN;
		end else begin
			case (state_q)
				pu_pkg::RUN: begin
					if (exec && is_store) begin
						state_q <= pu_pkg::STORE_WAIT;
					end else if (exec && is_halt) begin
						state_q <= pu_pkg::HALTED;
					end
				end
				pu_pkg::STORE_WAIT: begin
					if (store_done_i) begin
						state_q <= pu_pkg::RUN;
					end
				end
				default: state_q <= pu_pkg::HALTED;	// Held until reset
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < pu_pkg::GPR_CNT; i++) begin
				gpr_q[i] <= '0;
			end
		end else if (exec && wr_en) begin
			gpr_q[head_instr_i.rd] <= alu_res;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q      <= '0;
			next_pc_q <= rstaddr_i;
		end else if (pop_o) begin
			pc_q      <= next_pc_q;
			next_pc_q <= flush_o ? jmp_target : next_pc_q + pu_pkg::word_addr_t'(1);
		end
	end

	// A store head must survive the whole wait for the bus
	a_pop_has_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_o |-> head_valid_i);

endmodule

`default_nettype wire

//--- src.f
source/pu_pkg.sv
source/pu_memctrl.sv
source/pu_fetch.sv
source/pu_instr_buffer.sv
source/pu_sequencer.sv
source/pu.sv
testbench/tb_pu_mem.sv
testbench/tb_pu.sv

//--- testbench/tb_pu.sv
// ---------------------------------------------------------
// Processing unit testbench with program builder, register
// model, directed tests, timeout and summary
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_pu;

	localparam int TIMEOUT_CYCLES = 4000;	// 5 tests x 60 instrs x 8 cycles and a margin
	localparam int STORE_BASE     = 'h3c0;

	logic               clk = 1'b0;
	logic               rst_n;
	pu_pkg::word_addr_t rstaddr;
	pu_pkg::mem_op_e    pi1_op;
	pu_pkg::word_addr_t pi1_addr;
	pu_pkg::arch_word_t pi1_wdata;
	pu_pkg::arch_word_t pi1_rdata;
	logic               pi1_rdy;
	logic               halted;
	pu_pkg::word_addr_t pc;

	pu_pkg::arch_word_t model [pu_pkg::GPR_CNT];	// Architectural registers
	pu_pkg::word_addr_t exp_addrs [$];
	pu_pkg::arch_word_t exp_datas [$];
	pu_pkg::word_addr_t prog_pc;
	pu_pkg::word_addr_t halt_pc;
	logic [31:0] lfsr_q;
	int cycle_cnt;
	int test_errs;
	int pass_cnt;
	int fail_cnt;

	pu DUT (
		.clk_i(clk), .rst_n_i(rst_n), .rstaddr_i(rstaddr),
		.pi1_op_o(pi1_op), .pi1_addr_o(pi1_addr), .pi1_data_o(pi1_wdata),
		.pi1_data_i(pi1_rdata), .pi1_rdy_i(pi1_rdy),
		.halted_o(halted), .pc_o(pc)
	);

	tb_pu_mem u_mem (
		.clk_i(clk), .rst_n_i(rst_n),
		.op_i(pi1_op), .addr_i(pi1_addr), .data_i(pi1_wdata),
		.data_o(pi1_rdata), .rdy_o(pi1_rdy)
	);

	initial begin
		forever begin
			#5 clk = ~clk;
		end
	end

	// ---------------------------------------------------------
	// Helpers
	// ---------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		test_errs++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR: %s", msg);
		test_errs++;
	endtask

	// Writes one instruction and, on the taken path, applies it to the model
	task automatic put(input pu_pkg::opcode_e op, input int rd, input int rs,
		input pu_pkg::imm_t imm, input bit taken);
		pu_pkg::instr_t ins;
		ins.opcode = op;
		ins.rd     = pu_pkg::gpr_idx_t'(rd);
		ins.rs     = pu_pkg::gpr_idx_t'(rs);
		ins.imm    = imm;
		u_mem.mem[prog_pc[9:0]] = ins;
		if (taken) begin
			case (op)
				pu_pkg::OP_LI:  model[rd] = {{12{imm[19]}}, imm};
				pu_pkg::OP_ADD: model[rd] = model[rd] + model[rs];
				pu_pkg::OP_SUB: model[rd] = model[rd] - model[rs];
				pu_pkg::OP_XOR: model[rd] = model[rd] ^ model[rs];
				pu_pkg::OP_ST: begin
					exp_addrs.push_back(model[rs][29:0]);
					exp_datas.push_back(model[rd]);
				end
				pu_pkg::OP_HALT: halt_pc = prog_pc;
				default: begin
				end
			endcase
		end
		prog_pc = prog_pc + 30'd1;
	endtask

	task automatic hold_reset(input pu_pkg::word_addr_t start);
		@(negedge clk);
		rst_n     = 1'b0;
		rstaddr   = start;
		prog_pc   = start;
		halt_pc   = '0;
		test_errs = 0;
		u_mem.clear_all();
		exp_addrs.delete();
		exp_datas.delete();
		for (int i = 0; i < pu_pkg::GPR_CNT; i++) begin
			model[i] = '0;
		end
	endtask

	task automatic release_reset();
		repeat (8) begin
			@(negedge clk);
			if (pi1_op !== pu_pkg::MEMNOOP) begin
				report_mismatch("pi1_op_o", 32'(pi1_op), 32'(pu_pkg::MEMNOOP));
			end
			if (halted !== 1'b0) begin
				report_mismatch("halted_o", 32'(halted), 32'd0);
			end
		end
		rst_n = 1'b1;
	endtask

	task automatic wait_halted();
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		if (pc !== halt_pc) begin
			report_mismatch("pc_o", 32'(pc), 32'(halt_pc));
		end
	endtask

	task automatic check_stores();
		if (u_mem.store_addrs.size() != exp_addrs.size()) begin
			report_problem($sformatf("expected %0d stores but memory logged %0d",
				exp_addrs.size(), u_mem.store_addrs.size()));
		end else begin
			foreach (exp_addrs[i]) begin
				if (u_mem.store_addrs[i] !== exp_addrs[i]) begin
					report_mismatch("pi1_addr_o", 32'(u_mem.store_addrs[i]),
						32'(exp_addrs[i]));
				end
				if (u_mem.store_datas[i] !== exp_datas[i]) begin
					report_mismatch("pi1_data_o", u_mem.store_datas[i], exp_datas[i]);
				end
			end
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, test_errs);
		end
	endtask

	// ---------------------------------------------------------
	// Tests
	// ---------------------------------------------------------
	task automatic test_reset();
		hold_reset(30'h10);
		put(pu_pkg::OP_HALT, 0, 0, 20'h0, 1'b1);
		release_reset();
		@(negedge clk);
		if (pi1_op !== pu_pkg::MEMNOOP) begin
			report_mismatch("pi1_op_o", 32'(pi1_op), 32'(pu_pkg::MEMNOOP));
		end
		if (halted !== 1'b0) begin
			report_mismatch("halted_o", 32'(halted), 32'd0);
		end
		while (pi1_op === pu_pkg::MEMNOOP) begin
			@(negedge clk);
		end
		if (pi1_op !== pu_pkg::MEMREADOP) begin
			report_mismatch("pi1_op_o", 32'(pi1_op), 32'(pu_pkg::MEMREADOP));
		end
		if (pi1_addr !== rstaddr) begin
			report_mismatch("pi1_addr_o", 32'(pi1_addr), 32'(rstaddr));
		end
		wait_halted();
		end_test("reset");
	endtask

	task automatic test_alu_store();
		hold_reset(30'h20);
		put(pu_pkg::OP_LI, 1, 0, 20'h12345, 1'b1);
		put(pu_pkg::OP_LI, 2, 0, 20'hffff0, 1'b1);
		put(pu_pkg::OP_LI, 3, 0, 20'h80001, 1'b1);
		put(pu_pkg::OP_ADD, 1, 2, 20'h0, 1'b1);
		put(pu_pkg::OP_SUB, 3, 1, 20'h0, 1'b1);
		put(pu_pkg::OP_XOR, 2, 3, 20'h0, 1'b1);
		put(pu_pkg::OP_SUB, 4, 3, 20'h0, 1'b1);	// Wraps below zero
		put(pu_pkg::OP_LI, 10, 0, 20'h00300, 1'b1);
		put(pu_pkg::OP_ST, 1, 10, 20'h0, 1'b1);
		put(pu_pkg::OP_LI, 10, 0, 20'h00301, 1'b1);
		put(pu_pkg::OP_ST, 3, 10, 20'h0, 1'b1);
		put(pu_pkg::OP_LI, 10, 0, 20'h00302, 1'b1);
		put(pu_pkg::OP_ST, 2, 10, 20'h0, 1'b1);
		put(pu_pkg::OP_LI, 10, 0, 20'h00303, 1'b1);
		put(pu_pkg::OP_ST, 4, 10, 20'h0, 1'b1);
		put(pu_pkg::OP_HALT, 0, 0, 20'h0, 1'b1);
		release_reset();
		wait_halted();
		check_stores();
		end_test("alu_store");
	endtask

	task automatic test_jump();
		hold_reset(30'h40);
		put(pu_pkg::OP_LI, 1, 0, 20'h00011, 1'b1);
		put(pu_pkg::OP_LI, 5, 0, 20'h00200, 1'b1);
		put(pu_pkg::OP_LI, 2, 0, 20'h0dead, 1'b1);
		put(pu_pkg::OP_ST, 1, 5, 20'h0, 1'b1);
		put(pu_pkg::OP_JMP, 0, 0, 20'h00060, 1'b1);
		put(pu_pkg::OP_ST, 2, 5, 20'h0, 1'b0);	// Marker on the skipped path
		put(pu_pkg::OP_LI, 1, 0, 20'h00bad, 1'b0);
		put(pu_pkg::OP_ST, 1, 5, 20'h0, 1'b0);
		prog_pc = 30'h60;
		put(pu_pkg::OP_LI, 3, 0, 20'h00077, 1'b1);
		put(pu_pkg::OP_ST, 3, 5, 20'h0, 1'b1);
		put(pu_pkg::OP_ST, 1, 5, 20'h0, 1'b1);
		put(pu_pkg::OP_HALT, 0, 0, 20'h0, 1'b1);
		release_reset();
		wait_halted();
		check_stores();
		end_test("jump");
	endtask

	task automatic test_halt();
		pu_pkg::mem_op_e prev_op;
		hold_reset(30'h100);
		put(pu_pkg::OP_LI, 1, 0, 20'h00005, 1'b1);
		put(pu_pkg::OP_LI, 2, 0, 20'h00003, 1'b1);
		put(pu_pkg::OP_ADD, 1, 2, 20'h0, 1'b1);
		put(pu_pkg::opcode_e'(4'hf), 0, 0, 20'h0, 1'b1);
		put(pu_pkg::OP_HALT, 0, 0, 20'h0, 1'b1);
		put(pu_pkg::OP_LI, 3, 0, 20'h00001, 1'b0);
		put(pu_pkg::OP_ST, 1, 2, 20'h0, 1'b0);
		release_reset();
		wait_halted();
		prev_op = pi1_op;	// A read granted before halt may still be running
		repeat (20) begin
			@(negedge clk);
			if (prev_op == pu_pkg::MEMNOOP && pi1_op != pu_pkg::MEMNOOP) begin
				report_problem("a new pi1 request started after halt");
			end
			if (halted !== 1'b1) begin
				report_mismatch("halted_o", 32'(halted), 32'd1);
			end
			prev_op = pi1_op;
		end
		check_stores();
		end_test("halt");
	endtask

	task automatic test_random();
		pu_pkg::opcode_e op;
		int sel;
		int rd;
		int rs;
		int stores;
		hold_reset(30'h80);
		stores = 0;
		for (int n = 1; n <= 40; n++) begin
			sel = int'(rand_bits(2));
			rd  = int'(rand_bits(4)) % 15;	// r15 holds store addresses
			rs  = int'(rand_bits(4)) % 15;
			case (sel)
				0:       op = pu_pkg::OP_LI;
				1:       op = pu_pkg::OP_ADD;
				2:       op = pu_pkg::OP_SUB;
				default: op = pu_pkg::OP_XOR;
			endcase
			put(op, rd, rs, pu_pkg::imm_t'(rand_bits(20)), 1'b1);
			if (n % 5 == 0) begin
				put(pu_pkg::OP_LI, 15, 0, pu_pkg::imm_t'(STORE_BASE + stores), 1'b1);
				put(pu_pkg::OP_ST, rd, 15, 20'h0, 1'b1);
				stores++;
			end
		end
		put(pu_pkg::OP_HALT, 0, 0, 20'h0, 1'b1);
		release_reset();
		wait_halted();
		check_stores();
		end_test("random");
	endtask

	// ---------------------------------------------------------
	// Sequence, timeout and summary
	// ---------------------------------------------------------
	initial begin
		rst_n     = 1'b0;
		rstaddr   = '0;
		lfsr_q    = 32'hc3dfd92f;
		prog_pc   = '0;
		halt_pc   = '0;
		test_errs = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		test_reset();
		test_alu_store();
		test_jump();
		test_halt();
		test_random();
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("ERROR: timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_pu_mem.sv
// ---------------------------------------------------------
// Word memory model for pi1 with random wait states
// and a log of every store
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_pu_mem (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire pu_pkg::mem_op_e    op_i,
	input  wire pu_pkg::word_addr_t addr_i,
	input  wire pu_pkg::arch_word_t data_i,
	output pu_pkg::arch_word_t      data_o,
	output logic                    rdy_o
);

	localparam int MEM_WORDS = 1024;

	pu_pkg::arch_word_t mem [MEM_WORDS];
	pu_pkg::word_addr_t store_addrs [$];
	pu_pkg::arch_word_t store_datas [$];
	logic [31:0] lfsr_q = 32'hc3dfd92f;
	logic busy_q = 1'b0;
	int waits_q = 0;
	int remaining;

	initial begin
		rdy_o  = 1'b0;
		data_o = '0;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic clear_all();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {4'hf, 28'(i)};	// No-op opcode tagged with its address
		end
		store_addrs.delete();
		store_datas.delete();
	endtask

	// ---------------------------------------------------------
	// Answer one request at a time, 0 to 3 wait cycles each
	// ---------------------------------------------------------
	always @(negedge clk_i) begin
		rdy_o <= 1'b0;
		if (!rst_n_i) begin
			busy_q = 1'b0;
		end else if (op_i != pu_pkg::MEMNOOP) begin
			if (busy_q) begin
				remaining = waits_q;
			end else begin
				lfsr_q    = lfsr_next(lfsr_q);
				remaining = int'(lfsr_q[0]);
				lfsr_q    = lfsr_next(lfsr_q);
				remaining = remaining * 2 + int'(lfsr_q[0]);
			end
			if (remaining == 0) begin
				busy_q = 1'b0;
				rdy_o <= 1'b1;
				if (op_i == pu_pkg::MEMWRITEOP) begin
					mem[addr_i[9:0]] = data_i;
					store_addrs.push_back(addr_i);
					store_datas.push_back(data_i);
				end else begin
					data_o <= mem[addr_i[9:0]];
				end
			end else begin
				busy_q  = 1'b1;
				waits_q = remaining - 1;
			end
		end
	end

endmodule

`default_nettype wire
